// ==== design/lc_params.svh ====
/* link controller constants
   slot lengths in microseconds and counter widths */
`ifndef LC_PARAMS_SVH
`define LC_PARAMS_SVH

//////////////////////////////////////////////////
// slot timing, in 1us ticks
//////////////////////////////////////////////////
`define LC_SLOT_END    11'd624   // last count of one slot
`define LC_DSLOT_END   11'd1249  // last count of two slots

//////////////////////////////////////////////////
// counter widths
//////////////////////////////////////////////////
`define LC_US_CNT_W    11
`define LC_SLOT_CNT_W  16  // interval and window, in slots
`define LC_RAND_W      10
`define LC_FHS_CNT_W   5

`endif

// ==== design/lc_pkg.sv ====
/* link controller types
   inquiry-scan state encoding and counter types */
`include "lc_params.svh"

package lc_pkg;

  // inquiry-scan responder states
  typedef enum logic [2:0]
  {
    IS_STANDBY = 3'd0,
    IS_SCAN    = 3'd1,
    IS_TX_FHS  = 3'd2,  // first response slot pair
    IS_TX_EIR  = 3'd3,  // extended inquiry response slot
    IS_RAND    = 3'd4   // random backoff
  } is_state_e;

  typedef logic [`LC_SLOT_CNT_W-1:0] slot_cnt_t;
  typedef logic [`LC_US_CNT_W-1:0]   us_cnt_t;
  typedef logic [`LC_RAND_W-1:0]     rand_t;
  typedef logic [`LC_FHS_CNT_W-1:0]  fhs_cnt_t;

endpackage

// ==== design/resp_timer_if.sv ====
/* response timer interface
   run and clear levels from the FSM, end strobes from the timers */
`timescale 1ns/10ps

interface resp_timer_if;

  logic resp_run;      // response slot counter runs
  logic resp_clear;    // restart the response slot count
  logic backoff_run;   // backoff counter runs, held at 0 when low
  logic slot_endp;     // one slot done
  logic dslot_endp;    // two slots done
  logic backoff_endp;  // backoff reached max_rand

  modport ctrl
  (
    output resp_run, resp_clear, backoff_run,
    input  slot_endp, dslot_endp, backoff_endp
  );

  modport timer
  (
    input  resp_run, resp_clear, backoff_run,
    output slot_endp, dslot_endp, backoff_endp
  );

endinterface

// ==== design/scan_window_gen.sv ====
/* inquiry-scan window generator
   enable latch, slot counter modulo the scan interval,
   listen window and window-end strobe */
`timescale 1ns/10ps

module scan_window_gen
(
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              tslot_p,
  input  logic              scan_enable_p,
  input  logic              scan_cancel_p,
  input  lc_pkg::slot_cnt_t t_interval,
  input  lc_pkg::slot_cnt_t t_window,
  output logic              scan_window,
  output logic              window_endp
);

  logic              scan_en;    // set by enable strobe
  logic              scan_run;   // counting slots
  lc_pkg::slot_cnt_t slot_cnt;
  logic              window_d1;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      scan_en <= 1'b0;
    else if (scan_cancel_p)  // cancel wins over enable
      scan_en <= 1'b0;
    else if (scan_enable_p)
      scan_en <= 1'b1;
  end

  // slot counting starts at the first slot boundary after enable
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      scan_run <= 1'b0;
    else if (scan_cancel_p)
      scan_run <= 1'b0;
    else if (tslot_p && scan_en)
      scan_run <= 1'b1;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      slot_cnt <= '0;
    else if (tslot_p)
    begin
      if (!scan_run)
        slot_cnt <= '0;  // slot 0 of the first interval
      else if (slot_cnt == t_interval - 16'd1)
        slot_cnt <= '0;  // wrap at end of interval
      else
        slot_cnt <= slot_cnt + 16'd1;
    end
  end

  assign scan_window = scan_run & (slot_cnt < t_window);

  //////////////////////////////////////////////////
  // falling edge of the window
  //////////////////////////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      window_d1 <= 1'b0;
    else
      window_d1 <= scan_window;
  end

  assign window_endp = window_d1 & ~scan_window;

endmodule

// ==== design/slot_timers.sv ====
/* response and backoff timers
   1us slot counter for the tx slots, random backoff counter */
`timescale 1ns/10ps
`include "lc_params.svh"

module slot_timers
(
  input  logic          clk_6M,
  input  logic          rstz,
  input  logic          p_1us,
  input  lc_pkg::rand_t max_rand,
  resp_timer_if.timer   tmr
);

  lc_pkg::us_cnt_t us_cnt;       // ticks into the current tx slot
  lc_pkg::rand_t   backoff_cnt;

  //////////////////////////////////////////////////
  // response slot counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      us_cnt <= '0;
    else if (tmr.resp_clear)  // restart wins over counting
      us_cnt <= '0;
    else if (tmr.resp_run && p_1us)
      us_cnt <= us_cnt + 11'd1;
  end

  // strobes fire on the tick that finds the end count
  assign tmr.slot_endp  = p_1us & tmr.resp_run & (us_cnt == `LC_SLOT_END);
  assign tmr.dslot_endp = p_1us & tmr.resp_run & (us_cnt == `LC_DSLOT_END);

  //////////////////////////////////////////////////
  // random backoff
  //////////////////////////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      backoff_cnt <= '0;
    else if (!tmr.backoff_run)
      backoff_cnt <= '0;  // idle at zero
    else if (p_1us)
      backoff_cnt <= backoff_cnt + 10'd1;
  end

  assign tmr.backoff_endp = p_1us & tmr.backoff_run & (backoff_cnt == max_rand);

endmodule

// ==== design/inquiry_scan_fsm.sv ====
/* inquiry-scan state machine
   listen, FHS and EIR response, random backoff,
   tx start strobe and finished-response counter */
`timescale 1ns/10ps

module inquiry_scan_fsm
(
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             p_1us,
  input  logic             scan_window,
  input  logic             corre_hit,
  input  logic             eir_en,
  resp_timer_if.ctrl       tmr,
  output logic             inq_scan,
  output logic             inq_resp,
  output logic             tx_start_p,
  output lc_pkg::fhs_cnt_t fhs_count
);

  lc_pkg::is_state_e state;
  lc_pkg::is_state_e state_nxt;
  logic              hit_ok;   // accepted correlator hit
  logic              eir_go;   // start of the EIR slot

  //////////////////////////////////////////////////
  // state register, moves on 1us ticks only
  //////////////////////////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= lc_pkg::IS_STANDBY;
    else if (p_1us)
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      lc_pkg::IS_STANDBY:
      begin
        if (scan_window)
          state_nxt = lc_pkg::IS_SCAN;
      end
      lc_pkg::IS_SCAN:
      begin
        if (!scan_window)
          state_nxt = lc_pkg::IS_STANDBY;
        else if (corre_hit)
          state_nxt = lc_pkg::IS_TX_FHS;
      end
      lc_pkg::IS_TX_FHS:
      begin
        if (eir_en && tmr.dslot_endp)
          state_nxt = lc_pkg::IS_TX_EIR;
        else if (!eir_en && tmr.slot_endp)
          state_nxt = lc_pkg::IS_RAND;
      end
      lc_pkg::IS_TX_EIR:
      begin
        if (tmr.slot_endp)
          state_nxt = lc_pkg::IS_RAND;
      end
      lc_pkg::IS_RAND:
      begin
        if (tmr.backoff_endp)
          state_nxt = lc_pkg::IS_STANDBY;
      end
      default:
        state_nxt = lc_pkg::IS_STANDBY;
    endcase
  end

  //////////////////////////////////////////////////
  // tx start and timer control
  //////////////////////////////////////////////////
  assign hit_ok = p_1us & corre_hit & scan_window & (state == lc_pkg::IS_SCAN);
  assign eir_go = eir_en & tmr.dslot_endp & (state == lc_pkg::IS_TX_FHS);

  assign tx_start_p     = hit_ok | eir_go;
  assign tmr.resp_clear = hit_ok | eir_go;  // each tx slot counts from 0

  assign tmr.resp_run    = (state == lc_pkg::IS_TX_FHS) | (state == lc_pkg::IS_TX_EIR);
  assign tmr.backoff_run = (state == lc_pkg::IS_RAND);

  // listening only while the window is open
  assign inq_scan = (state == lc_pkg::IS_SCAN) & scan_window;
  assign inq_resp = tmr.resp_run;

  // one count per finished response, on entry to backoff
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      fhs_count <= '0;
    else if (p_1us && state_nxt == lc_pkg::IS_RAND && state != lc_pkg::IS_RAND)
      fhs_count <= fhs_count + 5'd1;
  end

endmodule

// ==== design/inquiry_scan_ctrl.sv ====
/* inquiry-scan responder top level
   window generator, state machine and slot timers */
`timescale 1ns/10ps

module inquiry_scan_ctrl
(
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              p_1us,
  input  logic              tslot_p,
  input  logic              scan_enable_p,
  input  logic              scan_cancel_p,
  input  lc_pkg::slot_cnt_t t_interval,
  input  lc_pkg::slot_cnt_t t_window,
  input  logic              eir_en,
  input  lc_pkg::rand_t     max_rand,
  input  logic              corre_hit,
  output logic              scan_window,
  output logic              window_endp,
  output logic              inq_scan,
  output logic              inq_resp,
  output logic              tx_start_p,
  output lc_pkg::fhs_cnt_t  fhs_count
);

  resp_timer_if tmr_if();  // FSM to timers

  scan_window_gen scan_window_gen_i
  (
    .clk_6M        (clk_6M       ),
    .rstz          (rstz         ),
    .tslot_p       (tslot_p      ),
    .scan_enable_p (scan_enable_p),
    .scan_cancel_p (scan_cancel_p),
    .t_interval    (t_interval   ),
    .t_window      (t_window     ),
    .scan_window   (scan_window  ),
    .window_endp   (window_endp  )
  );

  inquiry_scan_fsm inquiry_scan_fsm_i
  (
    .clk_6M      (clk_6M     ),
    .rstz        (rstz       ),
    .p_1us       (p_1us      ),
    .scan_window (scan_window),
    .corre_hit   (corre_hit  ),
    .eir_en      (eir_en     ),
    .tmr         (tmr_if.ctrl),
    .inq_scan    (inq_scan   ),
    .inq_resp    (inq_resp   ),
    .tx_start_p  (tx_start_p ),
    .fhs_count   (fhs_count  )
  );

  slot_timers slot_timers_i
  (
    .clk_6M   (clk_6M      ),
    .rstz     (rstz        ),
    .p_1us    (p_1us       ),
    .max_rand (max_rand    ),
    .tmr      (tmr_if.timer)
  );

endmodule

// ==== dv/inquiry_scan_properties.sv ====
/* concurrent checks on the inquiry-scan responder outputs
   bound to the RTL top level */
`timescale 1ns/10ps

module inquiry_scan_properties
(
  input logic             clk_6M,
  input logic             rstz,
  input logic             scan_window,
  input logic             inq_scan,
  input logic             inq_resp,
  input logic             tx_start_p,
  input lc_pkg::fhs_cnt_t fhs_count
);

  // tx starts from listening or from the FHS slot, a response slot follows
  tx_start_state: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_start_p |-> (inq_scan || inq_resp) ##1 inq_resp)
    else $error("tx_start_p outside scan or response");

  // one count per finished response, as inq_resp drops
  fhs_count_step: assert property (@(posedge clk_6M) disable iff (!rstz)
    (fhs_count != $past(fhs_count)) |->
      ((fhs_count == $past(fhs_count) + 5'd1) && $fell(inq_resp)))
    else $error("fhs_count moved by other than one");

  scan_in_window: assert property (@(posedge clk_6M) disable iff (!rstz)
    $rose(inq_scan) |-> $past(scan_window))  // listen only from an open window
    else $error("inq_scan rose without an open window");

endmodule

bind inquiry_scan_ctrl inquiry_scan_properties inquiry_scan_properties_i
(
  .clk_6M      (clk_6M     ),
  .rstz        (rstz       ),
  .scan_window (scan_window),
  .inq_scan    (inq_scan   ),
  .inq_resp    (inq_resp   ),
  .tx_start_p  (tx_start_p ),
  .fhs_count   (fhs_count  )
);

// ==== dv/inquiry_scan_tb.sv ====
/* inquiry-scan responder testbench
   clock, 1us and slot tick generator, directed tests,
   compare tasks and cycle limit */
`timescale 1ns/10ps
`include "lc_params.svh"

module inquiry_scan_tb;

  localparam int unsigned slot_ticks  = `LC_SLOT_END + 1;   // 625
  localparam int unsigned dslot_ticks = `LC_DSLOT_END + 1;  // 1250
  localparam int unsigned max_cycles  = 6 * 625 * 160;      // 160 slots, tests use about 32

  logic              clk_6M;
  logic              rstz;
  logic              p_1us, tslot_p, corre_hit;
  logic              scan_enable_p, scan_cancel_p, eir_en;
  lc_pkg::slot_cnt_t t_interval, t_window;
  lc_pkg::rand_t     max_rand;
  logic              scan_window, window_endp, inq_scan, inq_resp, tx_start_p;
  lc_pkg::fhs_cnt_t  fhs_count;

  int unsigned us_div  = 0;
  int unsigned tick_no = 0;     // 1us ticks since time 0
  int unsigned cycles  = 0;
  logic        hit_req = 1'b0;  // fire corre_hit on the next tick
  logic [31:0] rng     = 32'd14;

  inquiry_scan_ctrl inquiry_scan_ctrl_i (.*);

  initial
  begin
    clk_6M = 1'b0;
    forever #50 clk_6M = ~clk_6M;
  end

  // p_1us every 6 cycles, tslot_p on every 625th tick
  always @(negedge clk_6M)
  begin
    corre_hit = 1'b0;
    tslot_p   = 1'b0;
    p_1us     = (us_div == 5);
    us_div    = (us_div == 5) ? 0 : us_div + 1;
    if (p_1us)
    begin
      tick_no = tick_no + 1;
      tslot_p = (tick_no % 625 == 0);
      corre_hit = hit_req;
      hit_req   = 1'b0;
    end
  end

  always @(posedge clk_6M)
  begin
    cycles = cycles + 1;
    if (cycles >= max_cycles)
      stop_run("timeout: the tests did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////
  // compare tasks and helpers
  //////////////////////////////////////////////////
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_count(input string name, input lc_pkg::fhs_cnt_t got,
                             input lc_pkg::fhs_cnt_t exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_number(input string name, input int unsigned got,
                              input int unsigned exp);
    if (got != exp)
      stop_run($sformatf("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic lc_pkg::rand_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng[7:0];  // backoff 0 to 255
  endfunction

  // returns on the sample of the cycle that carried corre_hit
  task automatic send_hit();
    hit_req = 1'b1;
    @(posedge clk_6M);
    while (hit_req)
      @(posedge clk_6M);
  endtask

  task automatic start_scan(input lc_pkg::slot_cnt_t interval, input lc_pkg::slot_cnt_t window);
    @(negedge clk_6M);
    scan_cancel_p = 1'b1;
    @(negedge clk_6M);
    scan_cancel_p = 1'b0;
    t_interval    = interval;
    t_window      = window;
    scan_enable_p = 1'b1;
    @(negedge clk_6M);
    scan_enable_p = 1'b0;
    @(posedge clk_6M);
    while (!scan_window)
      @(posedge clk_6M);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic reset_values();
    @(posedge clk_6M);
    check_bit("scan_window", scan_window, 1'b0);
    check_bit("window_endp", window_endp, 1'b0);
    check_bit("inq_scan", inq_scan, 1'b0);
    check_bit("inq_resp", inq_resp, 1'b0);
    check_bit("tx_start_p", tx_start_p, 1'b0);
    check_count("fhs_count", fhs_count, 5'd0);
  endtask

  task automatic window_cycle();
    int unsigned slots;
    int unsigned endps;
    logic        win_open;
    start_scan(16'd4, 16'd2);
    slots = 0;
    endps = 0;
    while (slots < 8)  // two intervals
    begin
      @(posedge clk_6M);
      endps = endps + window_endp;
      if (tslot_p)
      begin
        win_open = ((slots % 4) < 2);  // first 2 slots of each interval
        slots    = slots + 1;
        check_bit("scan_window", scan_window, win_open);
        check_bit("inq_scan", inq_scan, win_open);
      end
    end
    check_number("window_endp pulses", endps, 2);
    @(negedge clk_6M);
    scan_cancel_p = 1'b1;
    @(negedge clk_6M);
    scan_cancel_p = 1'b0;
    slots = 0;
    while (slots < 5)
    begin
      @(posedge clk_6M);
      check_bit("scan_window", scan_window, 1'b0);
      check_bit("inq_scan", inq_scan, 1'b0);
      slots = slots + tslot_p;
    end
  endtask

  task automatic hit_outside_window();
    lc_pkg::fhs_cnt_t cnt0;
    int unsigned n;
    cnt0 = fhs_count;
    @(posedge clk_6M);
    send_hit();
    check_bit("tx_start_p", tx_start_p, 1'b0);
    for (n = 0; n < 60; n++)
    begin
      @(posedge clk_6M);
      check_bit("tx_start_p", tx_start_p, 1'b0);
      check_bit("inq_resp", inq_resp, 1'b0);
    end
    check_count("fhs_count", fhs_count, cnt0);
  endtask

  task automatic run_response(input logic eir, input lc_pkg::rand_t mr);
    lc_pkg::fhs_cnt_t cnt0;
    int unsigned t0;
    int unsigned n_tx;
    int unsigned resp_ticks;
    int unsigned tx_ticks;
    @(negedge clk_6M);
    eir_en   = eir;
    max_rand = mr;
    @(posedge clk_6M);
    while (!inq_scan)
      @(posedge clk_6M);
    cnt0 = fhs_count;
    send_hit();
    check_bit("tx_start_p", tx_start_p, 1'b1);
    t0         = tick_no;
    n_tx       = 1;
    resp_ticks = 0;
    tx_ticks   = eir ? dslot_ticks + slot_ticks : slot_ticks;  // FHS pair, then EIR slot
    do
    begin
      @(posedge clk_6M);
      if (tx_start_p)
      begin
        n_tx = n_tx + 1;
        check_number("EIR tx_start_p tick offset", tick_no - t0, dslot_ticks);
      end
      if (p_1us && inq_resp)
        resp_ticks = resp_ticks + 1;
    end
    while (!inq_scan);
    check_number("tx_start_p pulses", n_tx, eir ? 2 : 1);
    check_number("inq_resp ticks", resp_ticks, tx_ticks);
    // one tick into backoff, one back to scan
    check_number("return tick offset", tick_no - t0, tx_ticks + 2 + mr);
    check_count("fhs_count", fhs_count, cnt0 + 5'd1);
  endtask

  task automatic back_to_back();
    lc_pkg::fhs_cnt_t cnt0;
    int unsigned k;
    start_scan(16'd8, 16'd7);
    cnt0 = fhs_count;
    for (k = 0; k < 4; k++)
      run_response(1'b0, next_rand());
    check_count("fhs_count after four responses", fhs_count, cnt0 + 5'd4);
  endtask

  initial
  begin
    rstz          = 1'b0;
    p_1us         = 1'b0;
    tslot_p       = 1'b0;
    corre_hit     = 1'b0;
    scan_enable_p = 1'b0;
    scan_cancel_p = 1'b0;
    eir_en        = 1'b0;
    t_interval    = 16'd4;
    t_window      = 16'd2;
    max_rand      = '0;
    repeat (2) @(posedge clk_6M);
    @(negedge clk_6M);
    rstz = 1'b1;
    reset_values();
    window_cycle();
    hit_outside_window();
    start_scan(16'd8, 16'd7);
    run_response(1'b0, next_rand());
    start_scan(16'd8, 16'd7);
    run_response(1'b1, next_rand());
    back_to_back();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/lc_pkg.sv
design/resp_timer_if.sv
design/scan_window_gen.sv
design/slot_timers.sv
design/inquiry_scan_fsm.sv
design/inquiry_scan_ctrl.sv
dv/inquiry_scan_properties.sv
dv/inquiry_scan_tb.sv
